// ==== verilog/capture_pkg.sv ====
package capture_pkg;

	//////////////////////////////
	// Field widths
	//////////////////////////////
	localparam int COUNT_W  = 12;  // Line and pixel counters
	localparam int POS_W    = 16;  // Blanking position
	localparam int COLOR_W  = 8;
	localparam int NIBBLE_W = 4;
	localparam int ADE_CNT_W = 4;
	localparam int CHAR_W   = 8;

	localparam int PIXEL_WORD_W = 2 * COUNT_W + 3 * COLOR_W;  // 48
	localparam int AUX_WORD_W   = POS_W + 2 * NIBBLE_W + 1;   // 25

	typedef logic [COUNT_W-1:0]      count_t;
	typedef logic [POS_W-1:0]        pos_t;
	typedef logic [COLOR_W-1:0]      color_t;
	typedef logic [NIBBLE_W-1:0]     nibble_t;
	typedef logic [PIXEL_WORD_W-1:0] pixel_word_t;  // vcount, index, r, g, b
	typedef logic [AUX_WORD_W-1:0]   aux_word_t;    // pos, aux2, aux1, aux0[2]
	typedef logic [ADE_CNT_W-1:0]    ade_count_t;
	typedef logic [CHAR_W-1:0]       char_t;

	//////////////////////////////
	// Data island and text output
	//////////////////////////////
	localparam int ADE_PACKET_LEN = 32;  // Cycles per data-island packet

	localparam char_t ASCII_CR      = 8'd13;
	localparam char_t ASCII_LF      = 8'd10;
	localparam char_t ASCII_ZERO    = 8'h30;
	localparam char_t ASCII_UPPER_A = 8'h41;

	// Four hex digits then CR LF
	localparam int DUMP_CHARS = 6;

endpackage

// ==== verilog/line_pos_if.sv ====
`timescale 1ns/100ps

// Line and pixel position from the sync decoder to its users
interface line_pos_if;
	import capture_pkg::*;

	count_t hcount;       // Cycles since the last hsync rise
	count_t vcount;       // Lines since the last vsync rise
	count_t index;        // Pixel number within the active run
	logic   video_en;     // vde, one cycle late
	logic   video_start;  // First cycle of video_en
	logic   vactive;      // Line inside the active range

	modport timing (
		output hcount,
		output vcount,
		output index,
		output video_en,
		output video_start,
		output vactive
	);

	modport user (
		input hcount,
		input vcount,
		input index,
		input video_en,
		input video_start,
		input vactive
	);

endinterface

// ==== verilog/line_timing.sv ====
`timescale 1ns/100ps

module line_timing #(
	parameter int V_ACT_START = 25,
	parameter int V_ACT_LINES = 720
) (
	input  logic            rx0_pclk,
	input  logic            RSTBTN,
	input  logic            hsync,
	input  logic            vsync,
	input  logic            vde,
	line_pos_if.timing      pos
);
	import capture_pkg::*;

	localparam count_t V_FIRST = count_t'(V_ACT_START);
	localparam count_t V_LAST  = count_t'(V_ACT_START + V_ACT_LINES);  // One past the end

	logic hsync_q;
	logic vsync_q;
	logic hsync_rise;
	logic vsync_rise;

	// Edge seen while the input is high and its copy still low
	assign hsync_rise = hsync & ~hsync_q;
	assign vsync_rise = vsync & ~vsync_q;

	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			hsync_q <= 1'b0;
			vsync_q <= 1'b0;
		end else begin
			hsync_q <= hsync;
			vsync_q <= vsync;
		end
	end

	//////////////////////////////
	// Line and pixel counters
	//////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			pos.hcount <= '0;
			pos.vcount <= '0;
		end else begin
			if (hsync_rise) begin
				pos.hcount <= '0;
				pos.vcount <= pos.vcount + count_t'(1);
			end else begin
				pos.hcount <= pos.hcount + count_t'(1);
			end
			if (vsync_rise)
				pos.vcount <= '0;  // Frame start overrides the line step
		end
	end

	//////////////////////////////
	// Video enable and index
	//////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			pos.video_en    <= 1'b0;
			pos.video_start <= 1'b0;
			pos.index       <= '0;
		end else begin
			pos.video_en    <= vde;
			pos.video_start <= vde & ~pos.video_en;  // Lines up with the first video_en cycle
			if (pos.video_en)
				pos.index <= pos.index + count_t'(1);
			else
				pos.index <= '0;
		end
	end

	assign pos.vactive = (pos.vcount >= V_FIRST) && (pos.vcount < V_LAST);

endmodule

// ==== verilog/pixel_window.sv ====
`timescale 1ns/100ps

module pixel_window #(
	parameter int H_WIN_START = 220,
	parameter int H_WIN_END   = 1420
) (
	input  logic                     rx0_pclk,
	input  logic                     RSTBTN,
	input  capture_pkg::color_t      red,
	input  capture_pkg::color_t      green,
	input  capture_pkg::color_t      blue,
	line_pos_if.user                 pos,
	output capture_pkg::pixel_word_t pixel_word,
	output logic                     pixel_valid
);
	import capture_pkg::*;

	localparam count_t H_LO = count_t'(H_WIN_START);
	localparam count_t H_HI = count_t'(H_WIN_END);

	color_t red_q;
	color_t green_q;
	color_t blue_q;
	logic   in_window;

	// Same delay as vde to video_en
	always_ff @(posedge rx0_pclk) begin
		red_q   <= red;
		green_q <= green;
		blue_q  <= blue;
	end

	assign in_window = pos.video_en && pos.vactive &&
		(pos.hcount > H_LO) && (pos.hcount <= H_HI);

	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN)
			pixel_valid <= 1'b0;
		else
			pixel_valid <= in_window;
	end

	// Word is captured every cycle, qualified by pixel_valid
	always_ff @(posedge rx0_pclk) begin
		pixel_word <= {pos.vcount, pos.index, red_q, green_q, blue_q};
	end

endmodule

// ==== verilog/aux_capture.sv ====
`timescale 1ns/100ps

module aux_capture (
	input  logic                    rx0_pclk,
	input  logic                    RSTBTN,
	input  logic                    vde,
	input  logic                    ade,
	input  capture_pkg::nibble_t    aux0,
	input  capture_pkg::nibble_t    aux1,
	input  capture_pkg::nibble_t    aux2,
	line_pos_if.user                pos,
	output capture_pkg::aux_word_t  aux_word,
	output logic                    aux_valid,
	output capture_pkg::ade_count_t ade_num,
	output logic                    ade_num_valid,
	output logic                    packet_start,
	output capture_pkg::pos_t       packet_pos
);
	import capture_pkg::*;

	localparam int PKT_W = $clog2(ADE_PACKET_LEN);
	localparam logic [PKT_W-1:0] PKT_LAST = PKT_W'(ADE_PACKET_LEN - 1);

	pos_t             blank_pos;
	logic             init;
	logic [PKT_W-1:0] pkt_cnt;
	ade_count_t       ade_c;
	logic             pkt_first;

	//////////////////////////////
	// Blanking position
	//////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN)
			blank_pos <= '0;
		else if (vde)
			blank_pos <= '0;
		else
			blank_pos <= blank_pos + pos_t'(1);
	end

	// No aux words until video has been seen once
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN)
			init <= 1'b0;
		else if (pos.video_en)
			init <= 1'b1;
	end

	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN)
			aux_valid <= 1'b0;
		else
			aux_valid <= ade & init;
	end

	always_ff @(posedge rx0_pclk) begin
		aux_word <= {blank_pos, aux2, aux1, aux0[2]};  // Pre-update position
	end

	//////////////////////////////
	// Packet counting
	//////////////////////////////
	assign pkt_first = ade && (pkt_cnt == '0);

	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN)
			pkt_cnt <= '0;
		else if (!ade || pkt_cnt == PKT_LAST)
			pkt_cnt <= '0;
		else
			pkt_cnt <= pkt_cnt + 1'b1;
	end

	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			packet_start <= 1'b0;
		end else begin
			packet_start <= pkt_first;
		end
		packet_pos <= blank_pos;
	end

	// Count per line, handed over at each video start
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			ade_c         <= '0;
			ade_num       <= '0;
			ade_num_valid <= 1'b0;
		end else begin
			ade_num_valid <= pos.video_start;
			if (pos.video_start) begin
				ade_num <= ade_c;
				ade_c   <= pkt_first ? ade_count_t'(1) : '0;
			end else if (pkt_first) begin
				ade_c <= ade_c + ade_count_t'(1);
			end
		end
	end

endmodule

// ==== verilog/hex_dump.sv ====
`timescale 1ns/100ps

module hex_dump (
	input  logic              rx0_pclk,
	input  logic              RSTBTN,
	input  logic              packet_start,
	input  capture_pkg::pos_t packet_pos,
	output capture_pkg::char_t char_data,
	output logic              char_req,
	input  logic              char_ack
);
	import capture_pkg::*;

	typedef enum logic [1:0] {
		S_IDLE,
		S_REQUEST,  // char_req high, waiting for ack
		S_RELEASE   // char_req low, waiting for ack to drop
	} dump_state_t;

	dump_state_t state;
	pos_t        digits;    // Remaining digits, next one on top
	logic [2:0]  char_idx;  // Character now on char_data
	char_t       next_char;

	function automatic char_t hex_char(input nibble_t value);
		if (value < 4'd10)
			return ASCII_ZERO + char_t'(value);
		else
			return ASCII_UPPER_A + char_t'(value - 4'd10);
	endfunction

	// Character that follows the one at char_idx
	always_comb begin
		case (char_idx)
			3'd3:    next_char = ASCII_CR;
			3'd4:    next_char = ASCII_LF;
			default: next_char = hex_char(digits[15:12]);
		endcase
	end

	//////////////////////////////
	// Four-phase character FSM
	//////////////////////////////
	always_ff @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			state    <= S_IDLE;
			char_req <= 1'b0;
			char_idx <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (packet_start) begin
						char_data <= hex_char(packet_pos[15:12]);
						digits    <= {packet_pos[11:0], 4'h0};
						char_idx  <= '0;
						char_req  <= 1'b1;
						state     <= S_REQUEST;
					end
				end
				S_REQUEST: begin
					if (char_ack) begin
						char_req <= 1'b0;
						state    <= S_RELEASE;
					end
				end
				S_RELEASE: begin
					if (!char_ack) begin
						if (char_idx == 3'(DUMP_CHARS - 1)) begin
							state <= S_IDLE;  // Dump done, new packets accepted again
						end else begin
							char_data <= next_char;
							digits    <= {digits[11:0], 4'h0};
							char_idx  <= char_idx + 3'd1;
							char_req  <= 1'b1;
							state     <= S_REQUEST;
						end
					end
				end
				default: begin
					state    <= S_IDLE;
					char_req <= 1'b0;
				end
			endcase
		end
	end

endmodule

// ==== verilog/hdmi_capture_top.sv ====
`timescale 1ns/100ps

module hdmi_capture_top #(
	parameter int H_WIN_START = 220,
	parameter int H_WIN_END   = 1420,
	parameter int V_ACT_START = 25,
	parameter int V_ACT_LINES = 720
) (
	input  logic                     rx0_pclk,
	input  logic                     RSTBTN,
	// Decoded TMDS stream
	input  logic                     hsync,
	input  logic                     vsync,
	input  logic                     vde,
	input  logic                     ade,
	input  capture_pkg::color_t      red,
	input  capture_pkg::color_t      green,
	input  capture_pkg::color_t      blue,
	input  capture_pkg::nibble_t     aux0,
	input  capture_pkg::nibble_t     aux1,
	input  capture_pkg::nibble_t     aux2,
	// Captured words
	output capture_pkg::pixel_word_t pixel_word,
	output logic                     pixel_valid,
	output capture_pkg::aux_word_t   aux_word,
	output logic                     aux_valid,
	output capture_pkg::ade_count_t  ade_num,
	output logic                     ade_num_valid,
	// Character port
	output capture_pkg::char_t       char_data,
	output logic                     char_req,
	input  logic                     char_ack
);
	import capture_pkg::*;

	logic packet_start;
	pos_t packet_pos;

	line_pos_if line_pos ();

	line_timing #(
		.V_ACT_START (V_ACT_START),
		.V_ACT_LINES (V_ACT_LINES)
	) i_line_timing (
		.rx0_pclk (rx0_pclk),
		.RSTBTN   (RSTBTN),
		.hsync    (hsync),
		.vsync    (vsync),
		.vde      (vde),
		.pos      (line_pos.timing)
	);

	pixel_window #(
		.H_WIN_START (H_WIN_START),
		.H_WIN_END   (H_WIN_END)
	) i_pixel_window (
		.rx0_pclk    (rx0_pclk),
		.RSTBTN      (RSTBTN),
		.red         (red),
		.green       (green),
		.blue        (blue),
		.pos         (line_pos.user),
		.pixel_word  (pixel_word),
		.pixel_valid (pixel_valid)
	);

	aux_capture i_aux_capture (
		.rx0_pclk      (rx0_pclk),
		.RSTBTN        (RSTBTN),
		.vde           (vde),
		.ade           (ade),
		.aux0          (aux0),
		.aux1          (aux1),
		.aux2          (aux2),
		.pos           (line_pos.user),
		.aux_word      (aux_word),
		.aux_valid     (aux_valid),
		.ade_num       (ade_num),
		.ade_num_valid (ade_num_valid),
		.packet_start  (packet_start),
		.packet_pos    (packet_pos)
	);

	hex_dump i_hex_dump (
		.rx0_pclk     (rx0_pclk),
		.RSTBTN       (RSTBTN),
		.packet_start (packet_start),
		.packet_pos   (packet_pos),
		.char_data    (char_data),
		.char_req     (char_req),
		.char_ack     (char_ack)
	);

endmodule

// ==== bench/hdmi_capture_asserts.sv ====
`timescale 1ns/100ps

module hdmi_capture_asserts (
	input logic                rx0_pclk,
	input logic                RSTBTN,
	input logic                pixel_valid,
	input logic                aux_valid,
	input logic                ade_num_valid,
	input logic                char_req,
	input logic                char_ack,
	input capture_pkg::char_t  char_data
);

	//////////////////////////////
	// Character handshake
	//////////////////////////////
	req_held: assert property (@(posedge rx0_pclk) disable iff (RSTBTN)
		char_req && !char_ack |=> char_req)
		else $error("char_req dropped before char_ack arrived");

	data_stable: assert property (@(posedge rx0_pclk) disable iff (RSTBTN)
		char_req && !char_ack |=> $stable(char_data))
		else $error("char_data changed while char_req was waiting");

	// Registered outputs clear on any reset edge
	reset_quiet: assert property (@(posedge rx0_pclk)
		RSTBTN |=> !pixel_valid && !aux_valid && !ade_num_valid && !char_req)
		else $error("Output strobe high after a reset edge");

endmodule

bind hdmi_capture_top hdmi_capture_asserts i_asserts (
	.rx0_pclk      (rx0_pclk),
	.RSTBTN        (RSTBTN),
	.pixel_valid   (pixel_valid),
	.aux_valid     (aux_valid),
	.ade_num_valid (ade_num_valid),
	.char_req      (char_req),
	.char_ack      (char_ack),
	.char_data     (char_data)
);

// ==== bench/hdmi_capture_tb.sv ====
`timescale 1ns/100ps

module hdmi_capture_tb;
	import capture_pkg::*;

	localparam int H_START = 8;
	localparam int H_END   = 12;
	localparam int V_START = 2;
	localparam int V_LINES = 3;
	localparam int LINE_LEN = 240;

	logic rx0_pclk, RSTBTN, hsync, vsync, vde, ade, char_ack;
	color_t red, green, blue;
	nibble_t aux0, aux1, aux2;
	pixel_word_t pixel_word;
	aux_word_t aux_word;
	ade_count_t ade_num;
	char_t char_data;
	logic pixel_valid, aux_valid, ade_num_valid, char_req;

	integer seed = 25582;
	integer errors = 0;
	integer test_errors;
	integer dumps_started = 0;
	integer dumps_done = 0;
	integer chars_seen = 0;
	integer ignored_starts = 0;
	integer wait_cnt;
	logic   timed_out = 1'b0;
	char_t  char_q[$];
	char_t  exp_char;  // Character the receiver is acknowledging

	hdmi_capture_top #(
		.H_WIN_START (H_START),
		.H_WIN_END   (H_END),
		.V_ACT_START (V_START),
		.V_ACT_LINES (V_LINES)
	) i_dut (.*);

	always #10 rx0_pclk = ~rx0_pclk;

	//////////////////////////////
	// Reference model
	//////////////////////////////
	logic        m_hs_q, m_vs_q, m_ven, m_vstart, m_init;
	count_t      m_hcount, m_vcount, m_index;
	logic [23:0] m_col_q;
	pos_t        m_pos;
	logic [4:0]  m_pkt;
	ade_count_t  m_adec;
	logic        exp_pv, exp_av, exp_anv;
	pixel_word_t exp_pw;
	aux_word_t   exp_aw;
	ade_count_t  exp_an;
	logic        m_vact;
	logic        m_start;

	assign m_vact  = m_vcount >= V_START && m_vcount < V_START + V_LINES;
	assign m_start = ade && m_pkt == 5'd0;

	function automatic char_t to_hex(input logic [3:0] n);
		return (n < 10) ? char_t'(8'h30 + n) : char_t'(8'h37 + n);  // '0' or 'A'-10
	endfunction

	always @(posedge rx0_pclk) begin
		if (RSTBTN) begin
			m_hs_q <= 0;
			m_vs_q <= 0;
			m_hcount <= 0;
			m_vcount <= 0;
			m_index <= 0;
			m_ven <= 0;
			m_vstart <= 0;
			m_init <= 0;
			m_pos <= 0;
			m_pkt <= 0;
			m_adec <= 0;
			exp_pv <= 0;
			exp_av <= 0;
			exp_anv <= 0;
			exp_an <= 0;
		end else begin
			m_hs_q <= hsync;
			m_vs_q <= vsync;
			m_hcount <= (hsync && !m_hs_q) ? count_t'(0) : m_hcount + 1'b1;
			if (vsync && !m_vs_q)
				m_vcount <= 0;
			else if (hsync && !m_hs_q)
				m_vcount <= m_vcount + 1'b1;
			m_ven    <= vde;
			m_vstart <= vde && !m_ven;
			m_index  <= m_ven ? m_index + 1'b1 : count_t'(0);
			m_col_q  <= {red, green, blue};
			exp_pv <= m_ven && m_vact && m_hcount > H_START && m_hcount <= H_END;
			exp_pw <= {m_vcount, m_index, m_col_q};
			// Aux side
			m_pos  <= vde ? pos_t'(0) : m_pos + 1'b1;
			m_init <= m_init | m_ven;
			exp_av <= ade && m_init;
			exp_aw <= {m_pos, aux2, aux1, aux0[2]};
			m_pkt  <= (!ade || m_pkt == 5'd31) ? 5'd0 : m_pkt + 1'b1;
			exp_anv <= m_vstart;
			if (m_vstart) begin
				exp_an <= m_adec;
				m_adec <= 0;
			end else if (m_start) begin
				m_adec <= m_adec + 1'b1;
			end
			// Expected dump text, only when no dump is running
			if (m_start && dumps_started == dumps_done) begin
				char_q.push_back(to_hex(m_pos[15:12]));
				char_q.push_back(to_hex(m_pos[11:8]));
				char_q.push_back(to_hex(m_pos[7:4]));
				char_q.push_back(to_hex(m_pos[3:0]));
				char_q.push_back(ASCII_CR);
				char_q.push_back(ASCII_LF);
				dumps_started = dumps_started + 1;
			end else if (m_start) begin
				ignored_starts = ignored_starts + 1;
			end
		end
	end

	//////////////////////////////
	// Output checks
	//////////////////////////////
	chk_pv: assert property (@(posedge rx0_pclk) disable iff (RSTBTN) pixel_valid == exp_pv)
		else begin
			errors++;
			$display("ERROR %0t pixel_valid exp %b got %b", $time, $sampled(exp_pv),
				$sampled(pixel_valid));
		end
	chk_pw: assert property (@(posedge rx0_pclk) disable iff (RSTBTN)
		exp_pv |-> pixel_word == exp_pw)
		else begin
			errors++;
			$display("ERROR %0t pixel_word exp %h got %h", $time, $sampled(exp_pw),
				$sampled(pixel_word));
		end
	chk_av: assert property (@(posedge rx0_pclk) disable iff (RSTBTN) aux_valid == exp_av)
		else begin
			errors++;
			$display("ERROR %0t aux_valid exp %b got %b", $time, $sampled(exp_av),
				$sampled(aux_valid));
		end
	chk_aw: assert property (@(posedge rx0_pclk) disable iff (RSTBTN)
		exp_av |-> aux_word == exp_aw)
		else begin
			errors++;
			$display("ERROR %0t aux_word exp %h got %h", $time, $sampled(exp_aw),
				$sampled(aux_word));
		end
	chk_anv: assert property (@(posedge rx0_pclk) disable iff (RSTBTN)
		ade_num_valid == exp_anv)
		else begin
			errors++;
			$display("ERROR %0t ade_num_valid exp %b got %b", $time, $sampled(exp_anv),
				$sampled(ade_num_valid));
		end
	chk_an: assert property (@(posedge rx0_pclk) disable iff (RSTBTN)
		exp_anv |-> ade_num == exp_an)
		else begin
			errors++;
			$display("ERROR %0t ade_num exp %0d got %0d", $time, $sampled(exp_an),
				$sampled(ade_num));
		end
	chk_char: assert property (@(posedge rx0_pclk) disable iff (RSTBTN)
		$rose(char_ack) |-> char_data == exp_char)
		else begin
			errors++;
			$display("ERROR %0t char_data exp %h got %h", $time, $sampled(exp_char),
				$sampled(char_data));
		end

	//////////////////////////////
	// Character receiver
	//////////////////////////////
	integer ack_phase = 0;
	integer ack_wait = 0;

	always @(negedge rx0_pclk) begin
		if (RSTBTN) begin
			char_ack = 1'b0;
			ack_phase = 0;
		end else begin
			case (ack_phase)
				0: if (char_req) begin
					if (char_q.size() == 0) begin
						errors++;
						$display("Unexpected character %h at %0t", char_data, $time);
					end else begin
						exp_char = char_q.pop_front();
					end
					ack_wait = 3 + ({$random(seed)} % 8);
					ack_phase = 1;
				end
				1: if (ack_wait == 0) begin
					char_ack = 1'b1;
					ack_phase = 2;
				end else ack_wait--;
				2: if (!char_req) begin
					ack_wait = 3 + ({$random(seed)} % 8);
					ack_phase = 3;
				end
				default: if (ack_wait == 0) begin
					char_ack = 1'b0;
					chars_seen++;
					if (chars_seen % DUMP_CHARS == 0)
						dumps_done++;  // Sixth acknowledge dropped
					ack_phase = 0;
				end else ack_wait--;
			endcase
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	task automatic drive_line(input logic frame_start, input int ade_len, input logic video);
		for (int c = 0; c < LINE_LEN; c++) begin
			@(negedge rx0_pclk);
			hsync = c < 4;
			vsync = frame_start && c < 4;
			vde   = video && c >= 8 && c < 24;
			ade   = c >= 40 && c < 40 + ade_len;
			{red, green, blue} = $random(seed);
			{aux0, aux1, aux2} = $random(seed);
		end
	endtask

	task automatic report_test(input int num, input string name);
		$display("Test %0d %s finished with %0d errors", num, name, errors - test_errors);
		test_errors = errors;
	endtask

	initial begin
		rx0_pclk = 0;
		RSTBTN = 1;
		{hsync, vsync, vde, ade} = '0;
		{red, green, blue} = '0;
		{aux0, aux1, aux2} = '0;
		char_ack = 0;
		test_errors = 0;
		repeat (16) @(posedge rx0_pclk);
		@(negedge rx0_pclk);
		RSTBTN = 0;

		repeat (20) @(negedge rx0_pclk);  // Strobes stay low while idle
		report_test(1, "idle after reset");

		for (int f = 0; f < 2; f++)
			for (int l = 0; l < 6; l++)
				drive_line(l == 0, (l % 2) ? 64 : 32, !(f == 0 && l == 0));
		report_test(2, "frames with video and aux");

		wait_cnt = 0;
		while (!(dumps_done == dumps_started && char_q.size() == 0 && ack_phase == 0)
			&& wait_cnt < 2000) begin
			@(negedge rx0_pclk);
			wait_cnt++;
		end
		if (wait_cnt >= 2000) begin
			timed_out = 1'b1;
			$display("Timeout waiting for the character dumps to finish");
		end
		if (dumps_started == 0 || ignored_starts == 0) begin
			errors++;
			$display("Dump stimulus incomplete, %0d dumps, %0d ignored starts",
				dumps_started, ignored_starts);
		end
		report_test(3, "hex dumps over req/ack");

		$display("Tests run 3, dumps %0d, errors %0d", dumps_done, errors);
		if (errors != 0 || timed_out)
			$display("Simulation failed");
		else
			$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== hdmi_capture_top.f ====
verilog/capture_pkg.sv
verilog/line_pos_if.sv
verilog/line_timing.sv
verilog/pixel_window.sv
verilog/aux_capture.sv
verilog/hex_dump.sv
verilog/hdmi_capture_top.sv
bench/hdmi_capture_asserts.sv
bench/hdmi_capture_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module hdmi_capture_tb -f hdmi_capture_top.f -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" sim.log; then
	exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
	echo "No pass line in sim.log"
	exit 1
fi
exit 0
